// ==== common/cpu_pkg.sv ====
// opcode views, flag positions and stack constants for the RET cc path.
// only the 11ccc000 family is described here.
`default_nettype none

package cpu_pkg;

    // ############################################################
    // opcode byte
    // ############################################################

    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } opcode_fields_t;

    typedef struct packed {
        logic [1:0] prefix;
        logic [1:0] cc_group;   // opcode bit 5, then bit 4.
        logic       cc_sense;   // opcode bit 3.
        logic [2:0] low;
    } opcode_cond_t;

    typedef union packed {
        opcode_fields_t f;
        opcode_cond_t   c;
    } opcode_u;

    localparam logic [1:0] OP_X_RETCC = 2'd3;
    localparam logic [2:0] OP_Z_RETCC = 3'd0;

    // flag bit positions in the 4-bit flags word.
    localparam int FLAG_Z  = 0;
    localparam int FLAG_C  = 1;
    localparam int FLAG_PV = 2;
    localparam int FLAG_S  = 3;

    // cc_group encodings.
    localparam logic [1:0] CC_GROUP_Z  = 2'd0;
    localparam logic [1:0] CC_GROUP_C  = 2'd1;
    localparam logic [1:0] CC_GROUP_PV = 2'd2;
    localparam logic [1:0] CC_GROUP_S  = 2'd3;

    // stack.
    localparam logic [15:0] SP_RESET    = 16'h0100;
    localparam logic [15:0] PC_RESET    = 16'h0000;
    localparam int          STACK_DEPTH = 256;
    localparam int          STACK_AW    = $clog2(STACK_DEPTH);

endpackage

`default_nettype wire

// ==== common/seq_pkg.sv ====
// step numbers of the RET cc sequence.
`default_nettype none

package seq_pkg;

    localparam int XPT_W = 4;

    // ############################################################
    // step numbers
    // ############################################################

    localparam logic [XPT_W-1:0] XPT_IDLE  = 4'd0;
    localparam logic [XPT_W-1:0] XPT_FIRST = 4'd4;   // condition check.

    // low byte group.
    localparam logic [XPT_W-1:0] XPT_LOW_ADDR  = 4'd5;
    localparam logic [XPT_W-1:0] XPT_LOW_READ  = 4'd6;
    localparam logic [XPT_W-1:0] XPT_LOW_WRITE = 4'd7;

    // high byte group.
    localparam logic [XPT_W-1:0] XPT_HIGH_ADDR  = 4'd8;
    localparam logic [XPT_W-1:0] XPT_HIGH_READ  = 4'd9;
    localparam logic [XPT_W-1:0] XPT_HIGH_WRITE = 4'd10;

    localparam logic [XPT_W-1:0] XPT_LAST = XPT_HIGH_WRITE;

endpackage

`default_nettype wire

// ==== decode/ret_cc_decoder.sv ====
// combinational RET cc decode; all strobes are low while the sequencer is idle.
`timescale 1ns/1ps
`default_nettype none

module ret_cc_decoder
    import cpu_pkg::*;
    import seq_pkg::*;
(
    input  wire              active,
    input  wire  [XPT_W-1:0] xpt,
    input  wire  opcode_u    held_op,
    input  wire        [3:0] held_flags,
    output logic             reset_xpt,
    output logic             select_sp,
    output logic       [2:0] read_phase,
    output logic             inc_sp,
    output logic             write_pc_low,
    output logic             write_pc_high
);

    logic [XPT_LAST:XPT_FIRST] step;    // one-hot step decode.
    logic                      flag_zc;
    logic                      flag_pvs;
    logic                      flag_sel;
    logic                      cc_true;
    logic                      cancel;

    // ############################################################
    // XPT
    // ############################################################

    always_comb begin
        for (int i = XPT_FIRST; i <= XPT_LAST; i++) begin
            step[i] = active && (xpt == XPT_W'(i));
        end
    end

    // ############################################################
    // condition
    // ############################################################

    // first stage on opcode bit 4.
    assign flag_zc = (held_op.c.cc_group[0] == CC_GROUP_C[0]) ?
                     held_flags[FLAG_C] : held_flags[FLAG_Z];
    assign flag_pvs = (held_op.c.cc_group[0] == CC_GROUP_S[0]) ?
                      held_flags[FLAG_S] : held_flags[FLAG_PV];

    // second stage on opcode bit 5.
    assign flag_sel = (held_op.c.cc_group[1] == CC_GROUP_Z[1]) ? flag_zc : flag_pvs;

    assign cc_true = (flag_sel == held_op.c.cc_sense);
    assign cancel  = step[XPT_FIRST] && !cc_true;

    // ############################################################
    // strobes
    // ############################################################

    assign reset_xpt = cancel || step[XPT_LAST];   // cancel or 10.

    assign select_sp = |step[XPT_LAST:XPT_LOW_ADDR];   // 5 to 10.

    assign read_phase[0] = step[XPT_LOW_ADDR]  || step[XPT_HIGH_ADDR];  // 5 or 8.
    assign read_phase[1] = step[XPT_LOW_READ]  || step[XPT_HIGH_READ];  // 6 or 9.
    assign read_phase[2] = step[XPT_LOW_WRITE] || step[XPT_HIGH_WRITE]; // 7 or 10.

    assign inc_sp = read_phase[2];

    assign write_pc_low  = step[XPT_LOW_WRITE];
    assign write_pc_high = step[XPT_HIGH_WRITE];

endmodule

`default_nettype wire

// ==== decode/step_sequencer.sv ====
// XPT counter; loads the first step on start and stops on reset_xpt.
`timescale 1ns/1ps
`default_nettype none

module step_sequencer
    import seq_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              start,
    input  wire              reset_xpt,
    output logic [XPT_W-1:0] xpt,
    output logic             active
);

    logic [XPT_W-1:0] xpt_next;
    logic             active_next;

    // ############################################################
    // next step
    // ############################################################

    always_comb begin
        xpt_next    = xpt;
        active_next = active;
        if (reset_xpt) begin
            xpt_next    = XPT_IDLE;  // cancel or finish.
            active_next = 1'b0;
        end else if (start) begin
            xpt_next    = XPT_FIRST;
            active_next = 1'b1;
        end else if (active) begin
            xpt_next = xpt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xpt    <= XPT_IDLE;
            active <= 1'b0;
        end else begin
            xpt    <= xpt_next;
            active <= active_next;
        end
    end

    // the decoder must end the sequence at the last step.
    a_xpt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        xpt <= XPT_LAST);

endmodule

`default_nettype wire

// ==== fetch/opcode_latch.sv ====
// accepts only 11ccc000 bytes, and only while idle; other strobes are dropped.
`timescale 1ns/1ps
`default_nettype none

module opcode_latch
    import cpu_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          op_strobe,
    input  wire    [7:0] opcode,
    input  wire    [3:0] flags,
    input  wire          reset_xpt,
    output logic         start,
    output logic         busy,
    output opcode_u      held_op,
    output logic   [3:0] held_flags
);

    opcode_u op_in;
    logic    is_retcc;
    logic    accept;

    assign op_in = opcode;

    // x = 3 and z = 0.
    assign is_retcc = (op_in.f.x == OP_X_RETCC) && (op_in.f.z == OP_Z_RETCC);
    assign accept   = op_strobe && !busy && is_retcc;

    // ############################################################
    // control
    // ############################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
            busy  <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (reset_xpt) begin
                busy <= 1'b0; // instruction ends.
            end
        end
    end

    // held for the whole instruction.
    always_ff @(posedge clk) begin
        if (accept) begin
            held_op    <= op_in;
            held_flags <= flags;
        end
    end

    a_start_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> $rose(busy));

endmodule

`default_nettype wire

// ==== flist.f ====
common/cpu_pkg.sv
common/seq_pkg.sv
fetch/opcode_latch.sv
decode/step_sequencer.sv
decode/ret_cc_decoder.sv
stack/pc_sp_unit.sv
verilog/ret_core.sv
tb/tb_clock.sv
tb/ret_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ret_core testbench with Verilator and runs it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
    -f flist.f --top-module ret_core_tb -o ret_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/ret_core_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// ==== stack/pc_sp_unit.sv ====
// stack RAM addressed by SP[7:0]; a push writes two bytes in one cycle.
// pushes arriving while busy are dropped.
`timescale 1ns/1ps
`default_nettype none

module pc_sp_unit
    import cpu_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         push_strobe,
    input  wire  [15:0] push_data,
    input  wire         busy,
    input  wire         select_sp,
    input  wire   [2:0] read_phase,
    input  wire         inc_sp,
    input  wire         write_pc_low,
    input  wire         write_pc_high,
    input  wire         reset_xpt,
    output logic [15:0] pc,
    output logic [15:0] sp,
    output logic        done,
    output logic        taken
);

    logic [7:0]          stack_ram [STACK_DEPTH];
    logic [STACK_AW-1:0] rd_addr;
    logic [7:0]          rd_data;
    logic                push_ok;
    logic [STACK_AW-1:0] push_hi_addr;
    logic [STACK_AW-1:0] push_lo_addr;

    assign push_ok      = push_strobe && !busy;
    assign push_hi_addr = sp[STACK_AW-1:0] - STACK_AW'(1);
    assign push_lo_addr = sp[STACK_AW-1:0] - STACK_AW'(2);

    // ############################################################
    // stack RAM
    // ############################################################

    always_ff @(posedge clk) begin
        if (push_ok) begin
            stack_ram[push_hi_addr] <= push_data[15:8];
            stack_ram[push_lo_addr] <= push_data[7:0];
        end
        if (select_sp && read_phase[0]) begin
            rd_addr <= sp[STACK_AW-1:0];    // address phase.
        end
        if (read_phase[1]) begin
            rd_data <= stack_ram[rd_addr];
        end
    end

    // ############################################################
    // SP and PC
    // ############################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp <= SP_RESET;
            pc <= PC_RESET;
        end else begin
            if (push_ok) begin
                sp <= sp - 16'd2;
            end else if (inc_sp) begin
                sp <= sp + 16'd1;
            end
            if (write_pc_low) begin
                pc[7:0] <= rd_data;
            end
            if (write_pc_high) begin
                pc[15:8] <= rd_data;
            end
        end
    end

    // finish at step 10 means the return was taken.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done  <= 1'b0;
            taken <= 1'b0;
        end else begin
            done  <= reset_xpt;
            taken <= reset_xpt && write_pc_high;
        end
    end

    // sp moves only in the third read phase, after the byte is read.
    a_inc_with_sp: assert property (@(posedge clk) disable iff (!rst_n)
        inc_sp |-> select_sp && read_phase[2]);

endmodule

`default_nettype wire

// ==== tb/ret_core_tb.sv ====
// runs tb/ret_vectors.txt against ret_core; start the simulation from the project root.
// stops at the first error.
`timescale 1ns/1ps
`default_nettype none

module ret_core_tb
    import cpu_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        op_strobe;
    logic  [7:0] opcode;
    logic  [3:0] flags;
    logic        push_strobe;
    logic [15:0] push_data;
    logic [15:0] pc;
    logic [15:0] sp;
    logic        busy;
    logic        done;
    logic        taken;

    // one entry per vector line.
    logic  [1:0] v_kind  [$];
    logic [15:0] v_data  [$];
    logic  [7:0] v_op    [$];
    logic  [3:0] v_flags [$];
    logic [15:0] v_pc    [$];
    logic [15:0] v_sp    [$];
    logic        v_taken [$];

    integer seed        = 32'h6338;
    int     cycles      = 0;
    int     cycle_limit = 100;

    tb_clock tb_clock_inst (.clk(clk));

    ret_core ret_core_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_strobe   (op_strobe),
        .opcode      (opcode),
        .flags       (flags),
        .push_strobe (push_strobe),
        .push_data   (push_data),
        .pc          (pc),
        .sp          (sp),
        .busy        (busy),
        .done        (done),
        .taken       (taken)
    );

    // ############################################################
    // helpers
    // ############################################################

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("Mismatch in %s: %s expected %h, actual %h",
                               test, what, expected, actual));
        end
    endtask

    // the flag picked by opcode bits 5:4 must equal opcode bit 3.
    function automatic logic cond_holds(input logic [7:0] op, input logic [3:0] fl);
        logic flag;
        case (op[5:4])
            2'd0:    flag = fl[FLAG_Z];
            2'd1:    flag = fl[FLAG_C];
            2'd2:    flag = fl[FLAG_PV];
            default: flag = fl[FLAG_S];
        endcase
        return flag == op[3];
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [15:0] k, d, o, fl, epc, esp, et;
        fd = $fopen("tb/ret_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("could not open tb/ret_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h", k, d, o, fl, epc, esp, et);
            if (n == 7) begin   // comment and blank lines fall through.
                v_kind.push_back(k[1:0]);
                v_data.push_back(d);
                v_op.push_back(o[7:0]);
                v_flags.push_back(fl[3:0]);
                v_pc.push_back(epc);
                v_sp.push_back(esp);
                v_taken.push_back(et[0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_push(input logic [15:0] data);
        @(posedge clk);
        push_strobe <= 1'b1;
        push_data   <= data;
        @(posedge clk);
        push_strobe <= 1'b0;
        @(negedge clk);
    endtask

    // lat counts edges from the accepting edge to the one that raises done.
    task automatic run_ret(input string test, input logic [7:0] op, input logic [3:0] fl,
                           input logic inject, input logic [15:0] junk,
                           output int lat, output logic took);
        @(posedge clk);
        op_strobe <= 1'b1;
        opcode    <= op;
        flags     <= fl;
        @(posedge clk);
        lat = 0;
        forever begin
            if (inject && lat == 1) begin
                op_strobe   <= 1'b1;    // both strobes land while busy.
                flags       <= 4'($random(seed));
                push_strobe <= 1'b1;
                push_data   <= junk;
            end else begin
                op_strobe   <= 1'b0;
                push_strobe <= 1'b0;
            end
            @(negedge clk);
            if (lat == 0) begin
                assert (busy) else fail_run($sformatf("%s: opcode %h not accepted", test, op));
            end
            if (done) begin
                break;
            end
            @(posedge clk);
            lat++;
        end
        assert (!busy) else fail_run($sformatf("%s: busy still high with done", test));
        took = taken;
    endtask

    task automatic probe_bad_opcode(input string test, input logic [7:0] op,
                                    input logic [3:0] fl);
        @(posedge clk);
        op_strobe <= 1'b1;
        opcode    <= op;
        flags     <= fl;
        @(posedge clk);
        op_strobe <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (!busy && !done) else begin
                fail_run($sformatf("%s: opcode %h started an instruction", test, op));
            end
        end
    endtask

    // ############################################################
    // watchdog
    // ############################################################

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    // ############################################################
    // main sequence
    // ############################################################

    initial begin
        int    lat;
        logic  took;
        logic  exp_taken;
        string test;
        rst_n       <= 1'b0;
        op_strobe   <= 1'b0;
        opcode      <= 8'h00;
        flags       <= 4'h0;
        push_strobe <= 1'b0;
        push_data   <= 16'h0000;
        load_vectors();
        cycle_limit = v_kind.size() * 12 + 20;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset", "pc", 16'h0000, pc);
        check_value("reset", "sp", SP_RESET, sp);
        assert (!busy && !done && !taken) else fail_run("status outputs high after reset");

        for (int i = 0; i < v_kind.size(); i++) begin
            test = $sformatf("vector %0d", i);
            case (v_kind[i])
                2'd0: drive_push(v_data[i]);
                2'd2: probe_bad_opcode(test, v_op[i], v_flags[i]);
                default: begin
                    exp_taken = cond_holds(v_op[i], v_flags[i]);
                    assert (exp_taken == v_taken[i]) else begin
                        fail_run($sformatf("%s: vector taken disagrees with condition", test));
                    end
                    run_ret(test, v_op[i], v_flags[i], v_kind[i] == 2'd3, v_data[i],
                            lat, took);
                    check_value(test, "taken", 16'(exp_taken), 16'(took));
                    check_value(test, "latency", exp_taken ? 16'd8 : 16'd2, 16'(lat));
                end
            endcase
            check_value(test, "pc", v_pc[i], pc);
            check_value(test, "sp", v_sp[i], sp);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/ret_vectors.txt ====
// kind data opcode flags exp_pc exp_sp exp_taken (hex); flags are S PV C Z from bit 3 down
// kind 0 push, 1 ret cc, 2 byte outside 11ccc000, 3 ret cc with strobes while busy
0 1234 00 0 0000 00fe 0
1 0000 c0 0 1234 0100 1
1 0000 c0 1 1234 0100 0
0 5678 00 0 1234 00fe 0
1 0000 c8 1 5678 0100 1
1 0000 c8 e 5678 0100 0
0 9abc 00 0 5678 00fe 0
1 0000 d0 d 9abc 0100 1
1 0000 d0 2 9abc 0100 0
0 def0 00 0 9abc 00fe 0
1 0000 d8 2 def0 0100 1
1 0000 d8 d def0 0100 0
0 1357 00 0 def0 00fe 0
1 0000 e0 b 1357 0100 1
1 0000 e0 4 1357 0100 0
0 2468 00 0 1357 00fe 0
1 0000 e8 4 2468 0100 1
1 0000 e8 b 2468 0100 0
0 abcd 00 0 2468 00fe 0
1 0000 f0 7 abcd 0100 1
1 0000 f0 8 abcd 0100 0
0 beef 00 0 abcd 00fe 0
1 0000 f8 f beef 0100 1
1 0000 f8 7 beef 0100 0
2 0000 c9 0 beef 0100 0
2 0000 00 f beef 0100 0
0 1111 00 0 beef 00fe 0
0 2222 00 0 beef 00fc 0
1 0000 c0 0 2222 00fe 1
1 0000 d0 0 1111 0100 1
3 dead c8 0 1111 0100 0
0 4321 00 0 1111 00fe 0
3 cafe d8 2 4321 0100 1

// ==== tb/tb_clock.sv ====
// free-running testbench clock, 10 ns period.
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 5ns;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// ==== verilog/ret_core.sv ====
// RET cc core; push stands in for CALL, no program memory fetch.
`timescale 1ns/1ps
`default_nettype none

module ret_core
    import cpu_pkg::*;
    import seq_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         op_strobe,
    input  wire   [7:0] opcode,
    input  wire   [3:0] flags,
    input  wire         push_strobe,
    input  wire  [15:0] push_data,
    output logic [15:0] pc,
    output logic [15:0] sp,
    output logic        busy,
    output logic        done,
    output logic        taken
);

    logic             start;
    opcode_u          held_op;
    logic       [3:0] held_flags;
    logic [XPT_W-1:0] xpt;
    logic             active;
    logic             reset_xpt;
    logic             select_sp;
    logic       [2:0] read_phase;
    logic             inc_sp;
    logic             write_pc_low;
    logic             write_pc_high;

    // ############################################################
    // input side
    // ############################################################

    opcode_latch opcode_latch_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_strobe  (op_strobe),
        .opcode     (opcode),
        .flags      (flags),
        .reset_xpt  (reset_xpt),
        .start      (start),
        .busy       (busy),
        .held_op    (held_op),
        .held_flags (held_flags)
    );

    // ############################################################
    // processing
    // ############################################################

    step_sequencer step_sequencer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .reset_xpt (reset_xpt),
        .xpt       (xpt),
        .active    (active)
    );

    ret_cc_decoder ret_cc_decoder_inst (
        .active        (active),
        .xpt           (xpt),
        .held_op       (held_op),
        .held_flags    (held_flags),
        .reset_xpt     (reset_xpt),
        .select_sp     (select_sp),
        .read_phase    (read_phase),
        .inc_sp        (inc_sp),
        .write_pc_low  (write_pc_low),
        .write_pc_high (write_pc_high)
    );

    // ############################################################
    // output side
    // ############################################################

    pc_sp_unit pc_sp_unit_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .push_strobe   (push_strobe),
        .push_data     (push_data),
        .busy          (busy),
        .select_sp     (select_sp),
        .read_phase    (read_phase),
        .inc_sp        (inc_sp),
        .write_pc_low  (write_pc_low),
        .write_pc_high (write_pc_high),
        .reset_xpt     (reset_xpt),
        .pc            (pc),
        .sp            (sp),
        .done          (done),
        .taken         (taken)
    );

endmodule

`default_nettype wire
